//--- ret_pred_top.f
+incdir+include
logic/ret_pred_pkg.sv
logic/call_ret_decode.sv
logic/ras.sv
logic/next_pc_select.sv
logic/ret_pred_top.sv
verif/ret_pred_tb.sv

//--- Makefile
# Verilator build, run and lint for the return-address predictor

VERILATOR ?= verilator
TB_TOP    ?= ret_pred_tb
RTL_TOP   ?= ret_pred_top
FILELIST  ?= ret_pred_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := include/ret_pred_params.svh
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/ret_pred_tb.sv
//################################################
// Random-stimulus testbench for the return-address predictor
// Own classifier and circular stack model, compare tasks
// Watchdog and closing error report
//################################################

`timescale 1ns/1ps
`default_nettype none

`include "ret_pred_params.svh"

module ret_pred_tb;

    import ret_pred_pkg::*;

    localparam int HALF_PERIOD  = 4;                 // 8 ns clock
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_LEN     = 10;
    localparam int NEST_LEN     = `RAS_DEPTH * (`RAS_DEPTH + 1);   // Depths 1 to RAS_DEPTH
    localparam int OVER_CALLS   = `RAS_DEPTH + 4;    // Four more calls than entries
    localparam int RANDOM_LEN   = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_LEN + 1 + NEST_LEN + 2 * OVER_CALLS
                                  + 4 + 6 + RANDOM_LEN + 2;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * 2 * HALF_PERIOD;  // Twice the planned run

    localparam logic [6:0] OPCODE_JAL  = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR = 7'b1100111;
    localparam logic [6:0] OPCODE_OP   = 7'b0110011; // Replacement for accidental jumps

    logic               clk;
    logic               rst;
    logic               fetch_valid;
    logic [`XLEN-1:0]   fetch_pc;
    instr_u             fetch_instr;
    pred_t              pred;
    logic               pred_valid;

    logic [`XLEN-1:0]       m_addr [`RAS_DEPTH];     // Model stack entries
    logic [`RAS_DEPTH-1:0]  m_valid;                 // Model valid chain
    int                     m_top;                   // Model read index

    logic   exp_valid_q [$];                         // One expectation per driven cycle
    pred_t  exp_pred_q [$];
    string  exp_name_q [$];

    int pred_errors;
    int valid_errors;
    int other_errors;

    ret_pred_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .pred        (pred),
        .pred_valid  (pred_valid)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);          // ra and t0
    endfunction

    // Link register table of the calling convention
    function automatic cf_class_e classify(input logic [`XLEN-1:0] w);
        logic [4:0] rd;
        logic [4:0] rs1;
        rd  = w[11:7];
        rs1 = w[19:15];
        if (w[6:0] == OPCODE_JAL) begin
            return is_link(rd) ? CF_CALL : CF_JUMP;
        end
        if (w[6:0] == OPCODE_JALR) begin
            if (is_link(rd) && is_link(rs1)) begin
                return (rd == rs1) ? CF_CALL : CF_SWAP;
            end
            if (is_link(rd)) begin
                return CF_CALL;
            end
            if (is_link(rs1)) begin
                return CF_RETURN;
            end
            return CF_INDIRECT;
        end
        return CF_NONE;
    endfunction

    // Byte offset of a JAL taken straight from the J-type bit layout
    function automatic logic [`XLEN-1:0] jal_offset(input logic [`XLEN-1:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [`XLEN-1:0] encode_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic logic [`XLEN-1:0] encode_jalr(input logic [4:0] rd,
                                                     input logic [4:0] rs1,
                                                     input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPCODE_JALR};
    endfunction

    function automatic logic [`XLEN-1:0] random_other();
        logic [`XLEN-1:0] w;
        w = $urandom;
        if ((w[6:0] == OPCODE_JAL) || (w[6:0] == OPCODE_JALR)) begin
            w[6:0] = OPCODE_OP;                      // Keep it a non-jump word
        end
        return w;
    endfunction

    // Mostly x0, x1 and x5 so that every JALR class shows up often
    function automatic logic [4:0] pick_reg();
        int sel;
        sel = int'($urandom % 8);
        case (sel)
            0, 1:    return 5'd0;
            2, 3:    return 5'd1;
            4, 5:    return 5'd5;
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] random_word();
        int         kind;
        logic [20:0] off;
        kind   = int'($urandom % 8);
        off    = 21'($urandom);
        off[0] = 1'b0;
        if (kind < 3) begin
            return encode_jal(pick_reg(), off);
        end else if (kind < 6) begin
            return encode_jalr(pick_reg(), pick_reg(), 12'($urandom));
        end
        return random_other();
    endfunction

    function automatic logic [`XLEN-1:0] random_pc();
        return $urandom & 32'hffff_fffc;             // Word aligned
    endfunction

    // Queues the prediction for this word, then applies the stack rules
    task automatic model_step(input logic v, input logic [`XLEN-1:0] pc,
                              input logic [`XLEN-1:0] w, input string name);
        cf_class_e          cls;
        pred_t              exp;
        logic [`XLEN-1:0]   link;
        logic               push;
        logic               pop;
        cls         = classify(w);
        link        = pc + `XLEN'(4);
        exp.next_pc = link;
        exp.src     = SRC_SEQ;
        if (w[6:0] == OPCODE_JAL) begin
            exp.next_pc = pc + jal_offset(w);       // JAL is always a jump or a call
            exp.src     = SRC_JAL;
        end else if (((cls == CF_RETURN) || (cls == CF_SWAP)) && m_valid[m_top]) begin
            exp.next_pc = m_addr[m_top];
            exp.src     = SRC_RAS;
        end
        exp_valid_q.push_back(v);
        exp_pred_q.push_back(exp);
        exp_name_q.push_back(name);
        push = v && ((cls == CF_CALL) || (cls == CF_SWAP));
        pop  = v && ((cls == CF_RETURN) || (cls == CF_SWAP));
        if (push && pop) begin
            m_addr[m_top]  = link;                   // Swap rewrites the top in place
            m_valid[m_top] = 1'b1;
        end else if (push) begin
            if (m_valid[m_top]) begin
                m_top = (m_top + 1) % `RAS_DEPTH;
            end
            m_addr[m_top]  = link;
            m_valid[m_top] = 1'b1;
        end else if (pop) begin
            m_valid[m_top] = 1'b0;
            m_top          = (m_top + `RAS_DEPTH - 1) % `RAS_DEPTH;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            valid_errors++;
            $display("Fail %s: expected pred_valid %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_pred(input string name, input pred_t exp, input pred_t act);
        if (act !== exp) begin
            pred_errors++;
            $display("Fail %s: expected next_pc %h src %0d, actual next_pc %h src %0d",
                     name, exp.next_pc, exp.src, act.next_pc, act.src);
        end
    endtask

    // Checks the result registered at this edge, then drives the next word
    task automatic step(input logic v, input logic [`XLEN-1:0] pc,
                        input logic [`XLEN-1:0] w, input string name);
        logic   exp_v;
        pred_t  exp_p;
        string  exp_n;
        @(posedge clk);
        #1;
        if (exp_valid_q.size() == 0) begin
            other_errors++;
            $display("No expected result was queued before %s", name);
        end else begin
            exp_v = exp_valid_q.pop_front();
            exp_p = exp_pred_q.pop_front();
            exp_n = exp_name_q.pop_front();
            check_valid(exp_n, exp_v, pred_valid);
            if (exp_v) begin
                check_pred(exp_n, exp_p, pred);      // pred holds stale data when idle
            end
        end
        fetch_valid = v;
        fetch_pc    = pc;
        fetch_instr = w;
        model_step(v, pc, w, name);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [`XLEN-1:0] base;
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_instr  = '0;
        pred_errors  = 0;
        valid_errors = 0;
        other_errors = 0;
        m_valid      = '0;
        m_top        = 0;
        void'($urandom(82));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        exp_valid_q.push_back(1'b0);                 // Nothing was fetched during reset
        exp_pred_q.push_back('0);
        exp_name_q.push_back("reset");

        repeat (IDLE_LEN) step(1'b0, random_pc(), random_word(), "idle_after_reset");
        step(1'b1, random_pc(), encode_jalr(5'd0, 5'd1, 12'd0), "lone_return");

        for (int d = 1; d <= `RAS_DEPTH; d++) begin
            base = random_pc();
            for (int i = 0; i < d; i++) begin
                step(1'b1, base + 32'(i * 64), encode_jal(5'd1, 21'd256), "nested_call");
            end
            for (int i = 0; i < d; i++) begin
                step(1'b1, base + 32'(4096 + i * 4),
                     encode_jalr(5'd0, (i % 2 == 0) ? 5'd1 : 5'd5, 12'd0), "nested_return");
            end
        end

        base = random_pc();
        for (int i = 0; i < OVER_CALLS; i++) begin
            step(1'b1, base + 32'(i * 16), encode_jal(5'd5, 21'h1ffff0), "overflow_call");
        end
        for (int i = 0; i < OVER_CALLS; i++) begin
            step(1'b1, base + 32'(8192 + i * 4), encode_jalr(5'd0, 5'd5, 12'd0),
                 "overflow_return");
        end

        // Caller pushes, coroutine swaps x5 for x1, then both links unwind
        step(1'b1, 32'h0000_1000, encode_jal(5'd1, 21'h00400), "swap_setup_call");
        step(1'b1, 32'h0000_1400, encode_jalr(5'd5, 5'd1, 12'd0), "coroutine_swap");
        step(1'b1, 32'h0000_2000, encode_jalr(5'd0, 5'd5, 12'd0), "swap_return");
        step(1'b1, 32'h0000_1404, encode_jalr(5'd0, 5'd1, 12'd0), "swap_empty_return");

        step(1'b1, 32'h0000_3000, encode_jal(5'd0, 21'h00ffc), "jal_jump");
        step(1'b1, 32'h0000_4000, encode_jal(5'd1, 21'h1ff800), "jal_call");
        step(1'b1, 32'h0000_5000, encode_jalr(5'd6, 5'd7, 12'h010), "indirect");
        step(1'b1, 32'h0000_6000, encode_jalr(5'd1, 5'd6, 12'h020), "jalr_call");
        step(1'b1, 32'h0000_7000, random_other(), "ordinary");
        step(1'b1, 32'h0000_7004, random_other(), "ordinary");

        repeat (RANDOM_LEN) begin
            step(($urandom % 4) != 0, random_pc(), random_word(), "random_mix");
        end

        step(1'b0, '0, '0, "drain");
        step(1'b0, '0, '0, "drain");

        $display("Errors: pred %0d, pred_valid %0d, other %0d",
                 pred_errors, valid_errors, other_errors);
        if ((pred_errors + valid_errors + other_errors) == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/ret_pred_top.sv
//################################################
// Return-address prediction unit top level
// Decode, return stack and next pc selection
//################################################

`timescale 1ns/1ps
`default_nettype none

`include "ret_pred_params.svh"

module ret_pred_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 fetch_valid,
    input  wire logic [`XLEN-1:0]     fetch_pc,
    input  wire ret_pred_pkg::instr_u fetch_instr,
    output ret_pred_pkg::pred_t       pred,
    output logic                      pred_valid
);

    import ret_pred_pkg::*;

    decode_t            dec;                         // Combinational decode of this word
    stack_op_t          op;                          // Stack update for this edge
    logic [`XLEN-1:0]   top_addr;
    logic               top_valid;

    call_ret_decode u_decode (
        .pc    (fetch_pc),
        .instr (fetch_instr),
        .dec   (dec)
    );

    // Idle fetch cycles leave the stack alone, a swap does both and rewrites the top
    assign op = '{
        push:     fetch_valid && ((dec.cls == CF_CALL) || (dec.cls == CF_SWAP)),
        pop:      fetch_valid && ((dec.cls == CF_RETURN) || (dec.cls == CF_SWAP)),
        new_addr: dec.link_addr
    };

    ras u_ras (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .top_addr  (top_addr),
        .top_valid (top_valid)
    );

    next_pc_select u_select (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .dec         (dec),
        .top_addr    (top_addr),
        .top_valid   (top_valid),
        .pred        (pred),
        .pred_valid  (pred_valid)
    );

endmodule

`default_nettype wire

//--- logic/next_pc_select.sv
//################################################
// Next fetch address selection and output register
// Picks JAL target, stack top or fall through
//################################################

`timescale 1ns/1ps
`default_nettype none

`include "ret_pred_params.svh"

module next_pc_select (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fetch_valid,
    input  wire logic [`XLEN-1:0]      fetch_pc,
    input  wire ret_pred_pkg::decode_t dec,
    input  wire logic [`XLEN-1:0]      top_addr,
    input  wire logic                  top_valid,
    output ret_pred_pkg::pred_t        pred,
    output logic                       pred_valid
);

    import ret_pred_pkg::*;

    logic [`XLEN-1:0]   seq_pc;
    logic               use_jal;
    logic               use_ras;
    pred_t              pred_next;

    assign seq_pc = fetch_pc + `XLEN'(4);

    // Only JAL has a target known at fetch, a JALR call falls through
    assign use_jal = dec.is_jal && ((dec.cls == CF_JUMP) || (dec.cls == CF_CALL));

    // Returns and swaps go to the old top, an empty stack gives no hint
    assign use_ras = ((dec.cls == CF_RETURN) || (dec.cls == CF_SWAP)) && top_valid;

    always_comb begin
        if (use_jal) begin
            pred_next.next_pc = dec.target;
            pred_next.src     = SRC_JAL;
        end else if (use_ras) begin
            pred_next.next_pc = top_addr;
            pred_next.src     = SRC_RAS;
        end else begin
            pred_next.next_pc = seq_pc;              // Indirect jumps and plain words
            pred_next.src     = SRC_SEQ;
        end
    end

    // Valid output follows fetch_valid one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
        end
    end

    // The prediction itself only moves when fetch hands over a word
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pred <= pred_next;
        end
    end

    // A live prediction must be fully known or fetch would steer to a garbage address
    pred_known: assert property (
        @(posedge clk) disable iff (rst) pred_valid |-> !$isunknown(pred)
    ) else $error("Prediction is unknown while pred_valid is high");

endmodule

`default_nettype wire

//--- logic/ras.sv
//################################################
// Circular return address stack
// Entry storage with a valid chain, rolls over when full
//################################################

`timescale 1ns/1ps
`default_nettype none

`include "ret_pred_params.svh"

module ras (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire ret_pred_pkg::stack_op_t op,
    output logic [`XLEN-1:0]             top_addr,
    output logic                         top_valid
);

    localparam int IDX_W = $clog2(`RAS_DEPTH);

    logic [`XLEN-1:0]       entries [`RAS_DEPTH];    // Return addresses
    logic [`RAS_DEPTH-1:0]  valid_chain;             // One bit per entry, cleared by pops
    logic [IDX_W-1:0]       read_index;              // Current stack top
    logic [IDX_W-1:0]       write_index;             // Slot touched this cycle
    logic                   push_only;
    logic                   pop_only;

    assign push_only = op.push & ~op.pop;
    assign pop_only  = op.pop & ~op.push;

    // Top as seen before this cycle's operation lands
    assign top_addr  = entries[read_index];
    assign top_valid = valid_chain[read_index];

    // An empty top is reused, a valid one gets a new slot above it
    assign write_index = push_only ? read_index + IDX_W'(valid_chain[read_index])
                                   : read_index;     // Pop and swap both work in place

    always_ff @(posedge clk) begin
        if (op.push) begin
            entries[write_index] <= op.new_addr;     // Oldest entry is lost on wraparound
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_index <= '0;
        end else if (push_only) begin
            read_index <= write_index;               // Index wraps modulo the depth
        end else if (pop_only) begin
            read_index <= read_index - IDX_W'(1);
        end
    end

    // Pop alone marks the old top dead, anything with a push marks its slot live
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_chain <= '0;
        end else if (op.push | op.pop) begin
            valid_chain[write_index] <= op.push;
        end
    end

    // The top must stay known or a pop or push corrupts an unknown slot
    read_index_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(read_index)
    ) else $error("Stack read index is unknown");

endmodule

`default_nettype wire

//--- logic/call_ret_decode.sv
//################################################
// Jump classifier for the return-address predictor
// Sorts one word into call, return, swap, jump classes
// Forms the JAL target and the link address
//################################################

`timescale 1ns/1ps
`default_nettype none

`include "ret_pred_params.svh"

module call_ret_decode (
    input  wire logic [`XLEN-1:0]     pc,
    input  wire ret_pred_pkg::instr_u instr,
    output ret_pred_pkg::decode_t     dec
);

    import ret_pred_pkg::*;

    // The two registers the calling convention treats as a link
    localparam logic [4:0] REG_RA = 5'd1;            // Standard return address register
    localparam logic [4:0] REG_T0 = 5'd5;            // Alternate link used by millicode

    logic               is_jal;
    logic               is_jalr;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic               rd_link;
    logic               rs1_link;
    logic               same_reg;
    logic [`XLEN-1:0]   jal_offset;
    logic [`XLEN-1:0]   jal_target;
    logic [`XLEN-1:0]   link_addr;
    cf_class_e          cls;

    // Opcode sits in the same place in both views
    assign is_jal  = (instr.j.opcode == OPC_JAL);
    assign is_jalr = (instr.i.opcode == OPC_JALR);

    assign rd  = instr.i.rd;                         // Same bit position for J-type and I-type
    assign rs1 = instr.i.rs1;                        // Only meaningful for JALR

    assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
    assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);
    assign same_reg = (rd == rs1);

    // Unscramble imm[20|10:1|11|19:12] and sign extend it to a byte offset
    assign jal_offset = {
        {(`XLEN-20){instr.j.imm[19]}},               // Sign copies plus imm[20]
        instr.j.imm[7:0],                            // imm[19:12]
        instr.j.imm[8],                              // imm[11]
        instr.j.imm[18:9],                           // imm[10:1]
        1'b0                                         // Targets are halfword aligned
    };

    assign jal_target = pc + jal_offset;
    assign link_addr  = pc + `XLEN'(4);              // No compressed words so always plus 4

    // JAL only ever pushes or jumps, JALR follows the link register table
    always_comb begin
        cls = CF_NONE;                               // Any non-jump word
        if (is_jal) begin
            cls = rd_link ? CF_CALL : CF_JUMP;
        end else if (is_jalr) begin
            case ({rd_link, rs1_link})
                2'b10: begin
                    cls = CF_CALL;                   // Plain indirect call
                end
                2'b01: begin
                    cls = CF_RETURN;                 // Return through a link register
                end
                2'b11: begin
                    // Same link on both sides is a call, two different links swap coroutines
                    cls = same_reg ? CF_CALL : CF_SWAP;
                end
                default: begin
                    cls = CF_INDIRECT;               // Computed jump with no stack effect
                end
            endcase
        end
    end

    assign dec = '{
        cls:       cls,
        is_jal:    is_jal,
        target:    jal_target,
        link_addr: link_addr
    };

endmodule

`default_nettype wire

//--- logic/ret_pred_pkg.sv
//################################################
// Shared types for the return-address predictor
// Instruction union, decode result, stack op, prediction
//################################################

`default_nettype none

`include "ret_pred_params.svh"

package ret_pred_pkg;

    // Major opcodes of the two jump instructions
    localparam logic [6:0] OPC_JAL  = 7'b1101111;    // J-type jump and link
    localparam logic [6:0] OPC_JALR = 7'b1100111;    // I-type jump and link register

    // Control-flow class of one fetched word
    typedef enum logic [2:0] {
        CF_NONE     = 3'd0,                          // Not a jump
        CF_JUMP     = 3'd1,                          // JAL without a link destination
        CF_CALL     = 3'd2,                          // Pushes a return address
        CF_RETURN   = 3'd3,                          // Pops a return address
        CF_SWAP     = 3'd4,                          // Pops then pushes in one step
        CF_INDIRECT = 3'd5                           // JALR with no link register involved
    } cf_class_e;

    // Where the predicted next fetch address came from
    typedef enum logic [1:0] {
        SRC_SEQ = 2'd0,                              // Fall through to pc plus 4
        SRC_JAL = 2'd1,                              // Computed JAL target
        SRC_RAS = 2'd2                               // Top of the return stack
    } pred_src_e;

    // J-type view with the immediate still in its scrambled encoding
    typedef struct packed {
        logic [19:0] imm;                            // Word bits 31 to 12
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // I-type view as used by JALR
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // The same instruction word seen either way
    typedef union packed {
        j_fmt_t j;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        cf_class_e         cls;
        logic              is_jal;                   // Set when the word is a JAL of any kind
        logic [`XLEN-1:0]  target;                   // JAL target, only meaningful for JAL
        logic [`XLEN-1:0]  link_addr;                // Return address, pc plus 4
    } decode_t;

    typedef struct packed {
        logic              push;
        logic              pop;
        logic [`XLEN-1:0]  new_addr;                 // Address written on a push
    } stack_op_t;

    typedef struct packed {
        logic [`XLEN-1:0]  next_pc;
        pred_src_e         src;
    } pred_t;

endpackage

`default_nettype wire

//--- include/ret_pred_params.svh
//################################################
// Sizing macros for the return-address predictor
// Stack depth and address or instruction width
//################################################

`ifndef RET_PRED_PARAMS_SVH
`define RET_PRED_PARAMS_SVH

// Number of return stack entries, kept a power of two so the index wraps for free
`define RAS_DEPTH 8

// Width of fetch addresses and instruction words
`define XLEN 32

`endif
